// ==== hw/rv_mem_pkg.sv ====
package rv_mem_pkg;

	// Datapath width
	localparam int XLEN = 32;

	// Word address width of the data RAM, 256 words
	localparam int RAM_AW = 8;

	// Major opcodes handled by the LSU
	localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
	localparam logic [6:0] OPCODE_STORE = 7'b0100011;

	// Load widths
	localparam logic [2:0] FUNCT3_LB  = 3'b000;
	localparam logic [2:0] FUNCT3_LH  = 3'b001;
	localparam logic [2:0] FUNCT3_LW  = 3'b010;
	localparam logic [2:0] FUNCT3_LBU = 3'b100;
	localparam logic [2:0] FUNCT3_LHU = 3'b101;

	// Store widths
	localparam logic [2:0] FUNCT3_SB = 3'b000;
	localparam logic [2:0] FUNCT3_SH = 3'b001;
	localparam logic [2:0] FUNCT3_SW = 3'b010;

	// Controller FSM encoding
	localparam logic [2:0] LSU_IDLE = 3'd0;
	localparam logic [2:0] LSU_ADDR = 3'd1;
	localparam logic [2:0] LSU_REQ  = 3'd2;
	localparam logic [2:0] LSU_REL  = 3'd3;
	localparam logic [2:0] LSU_RESP = 3'd4;

	// Arbiter FSM encoding
	localparam logic [1:0] ARB_IDLE   = 2'd0;
	localparam logic [1:0] ARB_ACCESS = 2'd1;
	localparam logic [1:0] ARB_HOLD   = 2'd2;

	// One instruction word, read as I-type for loads and S-type for stores
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} instr_u;

endpackage

// ==== hw/data_ram.sv ====
module data_ram (
	input  logic                          CLK,
	input  logic                          we,
	input  logic [rv_mem_pkg::RAM_AW-1:0] addr,
	input  logic [rv_mem_pkg::XLEN-1:0]   wdata,
	input  logic [3:0]                    strb,
	output logic [rv_mem_pkg::XLEN-1:0]   rdata
);

	// Word storage
	logic [rv_mem_pkg::XLEN-1:0] mem [0:(1<<rv_mem_pkg::RAM_AW)-1];

	always_ff @(posedge CLK)
	begin
		// Byte lanes written per strobe bit
		if (we)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (strb[i])
					mem[addr][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
		// Registered read, old data on a same-cycle write
		rdata <= mem[addr];
	end

endmodule

// ==== hw/mem_arbiter.sv ====
module mem_arbiter (
	input  logic                          CLK,
	input  logic                          NRST,
	input  logic                          req0,
	input  logic [rv_mem_pkg::XLEN-1:0]   addr0,
	input  logic [rv_mem_pkg::XLEN-1:0]   wdata0,
	input  logic [3:0]                    strb0,
	output logic                          ack0,
	output logic [rv_mem_pkg::XLEN-1:0]   rdata0,
	input  logic                          req1,
	input  logic [rv_mem_pkg::XLEN-1:0]   addr1,
	input  logic [rv_mem_pkg::XLEN-1:0]   wdata1,
	input  logic [3:0]                    strb1,
	output logic                          ack1,
	output logic [rv_mem_pkg::XLEN-1:0]   rdata1,
	output logic [rv_mem_pkg::RAM_AW-1:0] ram_addr,
	output logic [rv_mem_pkg::XLEN-1:0]   ram_wdata,
	output logic [3:0]                    ram_strb,
	output logic                          ram_we,
	input  logic [rv_mem_pkg::XLEN-1:0]   ram_rdata
);

	logic [1:0] state;
	logic       gnt;
	logic       win;
	logic       gnt_req;

	// Tie goes to whoever was not granted last
	assign win     = (req0 && req1) ? ~gnt : req1;
	assign gnt_req = gnt ? req1 : req0;

	// Read data only alongside its own ack
	assign rdata0 = ack0 ? ram_rdata : '0;
	assign rdata1 = ack1 ? ram_rdata : '0;

	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			state  <= rv_mem_pkg::ARB_IDLE;
			gnt    <= 1'b1;
			ack0   <= 1'b0;
			ack1   <= 1'b0;
			ram_we <= 1'b0;
		end
		else
		begin
			case (state)
				rv_mem_pkg::ARB_IDLE:
				begin
					if (req0 || req1)
					begin
						gnt    <= win;
						ram_we <= win ? (|strb1) : (|strb0);
						state  <= rv_mem_pkg::ARB_ACCESS;
					end
				end
				rv_mem_pkg::ARB_ACCESS:
				begin
					// RAM has read or written by now
					ram_we <= 1'b0;
					ack0   <= ~gnt;
					ack1   <= gnt;
					state  <= rv_mem_pkg::ARB_HOLD;
				end
				rv_mem_pkg::ARB_HOLD:
				begin
					// Owner keeps the RAM until req drops
					if (!gnt_req)
					begin
						ack0  <= 1'b0;
						ack1  <= 1'b0;
						state <= rv_mem_pkg::ARB_IDLE;
					end
				end
				default:
				begin
					state <= rv_mem_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	// Winner's word address and write data
	always_ff @(posedge CLK)
	begin
		if ((state == rv_mem_pkg::ARB_IDLE) && (req0 || req1))
		begin
			ram_addr  <= win ? addr1[rv_mem_pkg::RAM_AW+1:2] : addr0[rv_mem_pkg::RAM_AW+1:2];
			ram_wdata <= win ? wdata1 : wdata0;
			ram_strb  <= win ? strb1 : strb0;
		end
	end

endmodule

// ==== hw/lsu_addr_gen.sv ====
module lsu_addr_gen (
	input  logic                        CLK,
	input  logic                        NRST,
	input  logic                        en,
	input  rv_mem_pkg::instr_u          instr,
	input  logic [rv_mem_pkg::XLEN-1:0] rs1,
	output logic [rv_mem_pkg::XLEN-1:0] addr,
	output logic [3:0]                  strb,
	output logic                        load_sext_b,
	output logic                        load_sext_h,
	output logic                        is_load,
	output logic                        is_store
);

	logic                        is_ld;
	logic                        is_st;
	logic [2:0]                  funct3;
	logic [rv_mem_pkg::XLEN-1:0] imm_i;
	logic [rv_mem_pkg::XLEN-1:0] imm_s;
	logic [rv_mem_pkg::XLEN-1:0] eff_addr;
	logic [3:0]                  byte_strb;
	logic [3:0]                  half_strb;
	logic [3:0]                  next_strb;

	// Opcode decode
	assign is_ld  = (instr.i.opcode == rv_mem_pkg::OPCODE_LOAD);
	assign is_st  = (instr.i.opcode == rv_mem_pkg::OPCODE_STORE);
	assign funct3 = instr.i.funct3;

	// Sign extended immediates, one per layout
	assign imm_i = {{(rv_mem_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{(rv_mem_pkg::XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

	// Stores take the split immediate
	assign eff_addr = rs1 + (is_st ? imm_s : imm_i);

	// Single lane per byte offset
	assign byte_strb = 4'b0001 << eff_addr[1:0];

	// Halfword lanes, offset 3 clamps to upper pair
	always_comb
	begin
		case (eff_addr[1:0])
			2'd0:    half_strb = 4'b0011;
			2'd1:    half_strb = 4'b0110;
			default: half_strb = 4'b1100;
		endcase
	end

	// Width select from funct3
	always_comb
	begin
		next_strb = 4'b0000;
		if (is_ld)
		begin
			case (funct3)
				rv_mem_pkg::FUNCT3_LB,
				rv_mem_pkg::FUNCT3_LBU: next_strb = byte_strb;
				rv_mem_pkg::FUNCT3_LH,
				rv_mem_pkg::FUNCT3_LHU: next_strb = half_strb;
				rv_mem_pkg::FUNCT3_LW:  next_strb = 4'b1111;
				default:                next_strb = 4'b1111;
			endcase
		end
		else if (is_st)
		begin
			case (funct3)
				rv_mem_pkg::FUNCT3_SB: next_strb = byte_strb;
				rv_mem_pkg::FUNCT3_SH: next_strb = half_strb;
				rv_mem_pkg::FUNCT3_SW: next_strb = 4'b1111;
				default:               next_strb = 4'b1111;
			endcase
		end
		// anything else keeps a zero strobe
	end

	// Flags and strobe
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			strb        <= 4'b0000;
			load_sext_b <= 1'b0;
			load_sext_h <= 1'b0;
			is_load     <= 1'b0;
			is_store    <= 1'b0;
		end
		else if (en)
		begin
			strb        <= next_strb;
			load_sext_b <= is_ld && (funct3 == rv_mem_pkg::FUNCT3_LB);
			load_sext_h <= is_ld && (funct3 == rv_mem_pkg::FUNCT3_LH);
			is_load     <= is_ld;
			is_store    <= is_st;
		end
	end

	// Effective address
	always_ff @(posedge CLK)
	begin
		if (en)
			addr <= eff_addr;
	end

endmodule

// ==== hw/lsu_ctrl.sv ====
module lsu_ctrl (
	input  logic                        CLK,
	input  logic                        NRST,
	input  logic                        cmd_req,
	input  rv_mem_pkg::instr_u          cmd_instr,
	input  logic [rv_mem_pkg::XLEN-1:0] cmd_rs1,
	input  logic [rv_mem_pkg::XLEN-1:0] cmd_rs2,
	output logic                        cmd_ack,
	output logic [rv_mem_pkg::XLEN-1:0] cmd_rdata,
	output logic                        m_req,
	output logic [rv_mem_pkg::XLEN-1:0] m_addr,
	output logic [rv_mem_pkg::XLEN-1:0] m_wdata,
	output logic [3:0]                  m_strb,
	input  logic                        m_ack,
	input  logic [rv_mem_pkg::XLEN-1:0] m_rdata
);

	logic [2:0]                  state;
	logic                        gen_en;
	logic [rv_mem_pkg::XLEN-1:0] addr;
	logic [3:0]                  strb;
	logic                        sext_b;
	logic                        sext_h;
	logic                        is_load;
	logic                        is_store;
	logic [rv_mem_pkg::XLEN-1:0] rs2_q;
	logic [1:0]                  lane;
	logic [4:0]                  shamt;
	logic                        is_half;
	logic [rv_mem_pkg::XLEN-1:0] ld_shifted;
	logic [rv_mem_pkg::XLEN-1:0] ld_data;

	// One enable pulse per accepted command
	assign gen_en = (state == rv_mem_pkg::LSU_IDLE) && cmd_req;

	lsu_addr_gen lsu_addr_gen_inst (
		.CLK         (CLK),
		.NRST        (NRST),
		.en          (gen_en),
		.instr       (cmd_instr),
		.rs1         (cmd_rs1),
		.addr        (addr),
		.strb        (strb),
		.load_sext_b (sext_b),
		.load_sext_h (sext_h),
		.is_load     (is_load),
		.is_store    (is_store)
	);

	// Lowest strobed lane sets the shift
	always_comb
	begin
		if (strb[0])
			lane = 2'd0;
		else if (strb[1])
			lane = 2'd1;
		else if (strb[2])
			lane = 2'd2;
		else
			lane = 2'd3;
	end

	assign shamt   = {lane, 3'b000};
	assign is_half = (strb == 4'b0011) || (strb == 4'b0110) || (strb == 4'b1100);

	// Request raised straight out of ADDR to save a cycle
	assign m_req   = ((state == rv_mem_pkg::LSU_ADDR) && (is_load || is_store)) ||
	                 (state == rv_mem_pkg::LSU_REQ);
	assign m_addr  = addr;
	// Loads read with a zero strobe
	assign m_strb  = is_store ? strb : 4'b0000;
	// Store data moved up to its first lane
	assign m_wdata = rs2_q << shamt;

	// Load data back down to lane 0
	assign ld_shifted = m_rdata >> shamt;

	// Width mask and sign extension
	always_comb
	begin
		if (strb == 4'b1111)
			ld_data = ld_shifted;
		else if (is_half)
			ld_data = {{(rv_mem_pkg::XLEN-16){sext_h & ld_shifted[15]}}, ld_shifted[15:0]};
		else
			ld_data = {{(rv_mem_pkg::XLEN-8){sext_b & ld_shifted[7]}}, ld_shifted[7:0]};
	end

	// Command and memory sequencing
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			state   <= rv_mem_pkg::LSU_IDLE;
			cmd_ack <= 1'b0;
		end
		else
		begin
			case (state)
				rv_mem_pkg::LSU_IDLE:
				begin
					if (cmd_req)
						state <= rv_mem_pkg::LSU_ADDR;
				end
				rv_mem_pkg::LSU_ADDR:
				begin
					// Non-memory opcode answers at once
					if (is_load || is_store)
					begin
						state <= rv_mem_pkg::LSU_REQ;
					end
					else
					begin
						cmd_ack <= 1'b1;
						state   <= rv_mem_pkg::LSU_RESP;
					end
				end
				rv_mem_pkg::LSU_REQ:
				begin
					// Ack host side as soon as data is in
					if (m_ack)
					begin
						cmd_ack <= 1'b1;
						state   <= rv_mem_pkg::LSU_REL;
					end
				end
				rv_mem_pkg::LSU_REL:
				begin
					// Wait out the arbiter release
					if (!m_ack)
						state <= rv_mem_pkg::LSU_RESP;
				end
				rv_mem_pkg::LSU_RESP:
				begin
					if (!cmd_req)
					begin
						cmd_ack <= 1'b0;
						state   <= rv_mem_pkg::LSU_IDLE;
					end
				end
				default:
				begin
					state <= rv_mem_pkg::LSU_IDLE;
				end
			endcase
		end
	end

	// Store operand and response data
	always_ff @(posedge CLK)
	begin
		if (gen_en)
			rs2_q <= cmd_rs2;
		if (state == rv_mem_pkg::LSU_ADDR)
			cmd_rdata <= '0;
		else if ((state == rv_mem_pkg::LSU_REQ) && m_ack)
			cmd_rdata <= is_load ? ld_data : '0;
	end

endmodule

// ==== hw/lsu_top.sv ====
module lsu_top (
	input  logic                        CLK,
	input  logic                        NRST,
	input  logic                        cmd_req,
	input  rv_mem_pkg::instr_u          cmd_instr,
	input  logic [rv_mem_pkg::XLEN-1:0] cmd_rs1,
	input  logic [rv_mem_pkg::XLEN-1:0] cmd_rs2,
	output logic                        cmd_ack,
	output logic [rv_mem_pkg::XLEN-1:0] cmd_rdata,
	input  logic                        host_req,
	input  logic [rv_mem_pkg::XLEN-1:0] host_addr,
	input  logic [rv_mem_pkg::XLEN-1:0] host_wdata,
	input  logic [3:0]                  host_strb,
	output logic                        host_ack,
	output logic [rv_mem_pkg::XLEN-1:0] host_rdata
);

	// LSU side of the arbiter
	logic                          lsu_m_req;
	logic [rv_mem_pkg::XLEN-1:0]   lsu_m_addr;
	logic [rv_mem_pkg::XLEN-1:0]   lsu_m_wdata;
	logic [3:0]                    lsu_m_strb;
	logic                          lsu_m_ack;
	logic [rv_mem_pkg::XLEN-1:0]   lsu_m_rdata;

	// RAM port
	logic [rv_mem_pkg::RAM_AW-1:0] ram_addr;
	logic [rv_mem_pkg::XLEN-1:0]   ram_wdata;
	logic [3:0]                    ram_strb;
	logic                          ram_we;
	logic [rv_mem_pkg::XLEN-1:0]   ram_rdata;

	lsu_ctrl lsu_ctrl_inst (
		.CLK       (CLK),
		.NRST      (NRST),
		.cmd_req   (cmd_req),
		.cmd_instr (cmd_instr),
		.cmd_rs1   (cmd_rs1),
		.cmd_rs2   (cmd_rs2),
		.cmd_ack   (cmd_ack),
		.cmd_rdata (cmd_rdata),
		.m_req     (lsu_m_req),
		.m_addr    (lsu_m_addr),
		.m_wdata   (lsu_m_wdata),
		.m_strb    (lsu_m_strb),
		.m_ack     (lsu_m_ack),
		.m_rdata   (lsu_m_rdata)
	);

	// LSU on port 0, host on port 1
	mem_arbiter mem_arbiter_inst (
		.CLK       (CLK),
		.NRST      (NRST),
		.req0      (lsu_m_req),
		.addr0     (lsu_m_addr),
		.wdata0    (lsu_m_wdata),
		.strb0     (lsu_m_strb),
		.ack0      (lsu_m_ack),
		.rdata0    (lsu_m_rdata),
		.req1      (host_req),
		.addr1     (host_addr),
		.wdata1    (host_wdata),
		.strb1     (host_strb),
		.ack1      (host_ack),
		.rdata1    (host_rdata),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_strb  (ram_strb),
		.ram_we    (ram_we),
		.ram_rdata (ram_rdata)
	);

	data_ram data_ram_inst (
		.CLK   (CLK),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.strb  (ram_strb),
		.rdata (ram_rdata)
	);

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic CLK,
	output logic NRST
);

	timeunit 1ns;
	timeprecision 10ps;

	// 20 ns period
	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Low for three rising edges, released on a falling edge
	initial
	begin
		NRST = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		NRST = 1'b1;
	end

endmodule

// ==== verif/tb_lsu_top.sv ====
module tb_lsu_top;

	timeunit 1ns;
	timeprecision 10ps;

	// Cycles allowed per handshake edge
	localparam int TIMEOUT = 50;

	// One table row for the host port or the command port
	typedef struct packed {
		logic        host;
		logic        chk;
		logic [31:0] ctl;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] exp_data;
	} row_t;

	logic               CLK;
	logic               NRST;
	logic               cmd_req;
	rv_mem_pkg::instr_u cmd_instr;
	logic [31:0]        cmd_rs1;
	logic [31:0]        cmd_rs2;
	logic               cmd_ack;
	logic [31:0]        cmd_rdata;
	logic               host_req;
	logic [31:0]        host_addr;
	logic [31:0]        host_wdata;
	logic [3:0]         host_strb;
	logic               host_ack;
	logic [31:0]        host_rdata;

	row_t        rows[$];
	// Word indexed shadow of the data RAM
	logic [31:0] shadow [0:255];
	logic [31:0] rng;

	tb_clk_gen tb_clk_gen_inst (
		.CLK  (CLK),
		.NRST (NRST)
	);

	lsu_top lsu_top_inst (
		.CLK        (CLK),
		.NRST       (NRST),
		.cmd_req    (cmd_req),
		.cmd_instr  (cmd_instr),
		.cmd_rs1    (cmd_rs1),
		.cmd_rs2    (cmd_rs2),
		.cmd_ack    (cmd_ack),
		.cmd_rdata  (cmd_rdata),
		.host_req   (host_req),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_strb  (host_strb),
		.host_ack   (host_ack),
		.host_rdata (host_rdata)
	);

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Lanes touched by an access of the given size code
	function automatic logic [3:0] lanes_for(input logic [1:0] size, input logic [1:0] off);
		logic [3:0] s;
		if (size == 2'd0)
			s = 4'b0001 << off;
		else if (size == 2'd1)
			s = (off == 2'd0) ? 4'b0011 : ((off == 2'd1) ? 4'b0110 : 4'b1100);
		else
			s = 4'b1111;
		return s;
	endfunction

	function automatic int low_lane(input logic [3:0] strb);
		int lo;
		lo = 0;
		for (int i = 3; i >= 0; i--)
			if (strb[i])
				lo = i;
		return lo;
	endfunction

	// Store data starts at the lowest strobed lane
	function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		int          lo;
		res = old;
		lo  = low_lane(strb);
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[8*i +: 8] = data[8*(i-lo) +: 8];
		return res;
	endfunction

	// Expected load result from one shadow word
	function automatic logic [31:0] load_model(input logic [31:0] word, input logic [2:0] f3,
			input logic [1:0] off);
		logic [31:0] sh;
		logic [31:0] res;
		sh = word >> (8 * low_lane(lanes_for(f3[1:0], off)));
		case (f3)
			rv_mem_pkg::FUNCT3_LB:  res = {{24{sh[7]}}, sh[7:0]};
			rv_mem_pkg::FUNCT3_LBU: res = {24'h0, sh[7:0]};
			rv_mem_pkg::FUNCT3_LH:  res = {{16{sh[15]}}, sh[15:0]};
			rv_mem_pkg::FUNCT3_LHU: res = {16'h0, sh[15:0]};
			default:                res = word;
		endcase
		return res;
	endfunction

	// rs1 in x1, rd in x2, rs2 in x3
	function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [11:0] imm);
		return {imm, 5'd1, f3, 5'd2, rv_mem_pkg::OPCODE_LOAD};
	endfunction

	function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
		return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], rv_mem_pkg::OPCODE_STORE};
	endfunction

	function automatic void add_row(input logic host, input logic chk, input logic [31:0] ctl,
			input logic [31:0] a, input logic [31:0] d, input logic [31:0] exp_data);
		rows.push_back({host, chk, ctl, a, d, exp_data});
	endfunction

	function automatic void add_host_write(input int w, input logic [31:0] data);
		shadow[w] = data;
		add_row(1'b1, 1'b0, 32'hf, 32'(w * 4), data, 32'h0);
	endfunction

	function automatic void add_host_read(input int w);
		add_row(1'b1, 1'b1, 32'h0, 32'(w * 4), 32'h0, shadow[w]);
	endfunction

	// rs1 backed off by the sign-extended immediate
	function automatic void add_store(input logic [2:0] f3, input int w, input int off,
			input logic [11:0] imm, input logic [31:0] data);
		logic [31:0] rs1;
		rs1       = 32'(w * 4 + off) - {{20{imm[11]}}, imm};
		shadow[w] = merge_store(shadow[w], data, lanes_for(f3[1:0], 2'(off)));
		add_row(1'b0, 1'b0, enc_store(f3, imm), rs1, data, 32'h0);
	endfunction

	function automatic void add_load(input logic [2:0] f3, input int w, input int off,
			input logic [11:0] imm);
		logic [31:0] rs1;
		rs1 = 32'(w * 4 + off) - {{20{imm[11]}}, imm};
		add_row(1'b0, 1'b1, enc_load(f3, imm), rs1, next_rand(),
			load_model(shadow[w], f3, 2'(off)));
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "test stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp_data);
		assert (got === exp_data)
		else
		begin
			$display("error at %0d ns: %s read %h, expected %h", $time, what, got, exp_data);
			$display("STATUS: FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	// Four-phase command with the result sampled while ack is high
	task automatic run_cmd(input logic [31:0] instr, input logic [31:0] rs1,
			input logic [31:0] rs2, output logic [31:0] rdata, output time t_ack);
		int n;
		@(negedge CLK);
		cmd_instr = instr;
		cmd_rs1   = rs1;
		cmd_rs2   = rs2;
		cmd_req   = 1'b1;
		n = 0;
		while (cmd_ack !== 1'b1)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				fail_stop("timeout: cmd_ack never rose");
		end
		rdata   = cmd_rdata;
		t_ack   = $time;
		cmd_req = 1'b0;
		n = 0;
		while (cmd_ack !== 1'b0)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				fail_stop("timeout: cmd_ack never fell");
		end
	endtask

	// Zero strobe reads and any other strobe writes
	task automatic host_access(input logic [3:0] strb, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output time t_ack);
		int n;
		@(negedge CLK);
		host_strb  = strb;
		host_addr  = addr;
		host_wdata = wdata;
		host_req   = 1'b1;
		n = 0;
		while (host_ack !== 1'b1)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				fail_stop("timeout: host_ack never rose");
		end
		rdata    = host_rdata;
		t_ack    = $time;
		host_req = 1'b0;
		n = 0;
		while (host_ack !== 1'b0)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				fail_stop("timeout: host_ack never fell");
		end
	endtask

	function automatic void build_table();
		// Host preload and readback
		for (int w = 0; w < 16; w++)
			add_host_write(w, next_rand());
		for (int w = 0; w < 16; w++)
			add_host_read(w);
		// Stores at every offset with all widths on the same word
		for (int off = 0; off < 4; off++)
		begin
			add_store(rv_mem_pkg::FUNCT3_SB, 8 + off, off, 12'd24, next_rand());
			add_host_read(8 + off);
			add_store(rv_mem_pkg::FUNCT3_SH, 8 + off, off, 12'd24, next_rand());
			add_host_read(8 + off);
			add_store(rv_mem_pkg::FUNCT3_SW, 8 + off, off, 12'd24, next_rand());
			add_host_read(8 + off);
		end
		// Loads from a word with sign bits set in the low lanes
		add_host_write(20, next_rand() | 32'h0000_8080);
		for (int off = 0; off < 4; off++)
		begin
			add_load(rv_mem_pkg::FUNCT3_LB, 20, off, 12'd4);
			add_load(rv_mem_pkg::FUNCT3_LBU, 20, off, 12'd4);
			add_load(rv_mem_pkg::FUNCT3_LH, 20, off, 12'd4);
			add_load(rv_mem_pkg::FUNCT3_LHU, 20, off, 12'd4);
			add_load(rv_mem_pkg::FUNCT3_LW, 20, off, 12'd4);
		end
		// Negative immediates in the S and I layouts
		add_store(rv_mem_pkg::FUNCT3_SW, 30, 0, 12'hfec, next_rand());
		add_store(rv_mem_pkg::FUNCT3_SB, 30, 1, 12'hff8, next_rand());
		add_host_read(30);
		add_load(rv_mem_pkg::FUNCT3_LW, 30, 0, 12'h800);
		add_load(rv_mem_pkg::FUNCT3_LH, 30, 2, 12'hff0);
		// R-type ADD aimed at word 20 must leave memory alone
		add_row(1'b0, 1'b1, {12'h0, 5'd1, 3'b000, 5'd2, 7'b0110011}, 32'd80, next_rand(),
			32'h0);
		add_host_read(20);
	endfunction

	// Host raised while the LSU owns the RAM
	task automatic run_contention();
		logic [31:0] load_exp;
		logic [31:0] host_data;
		logic [31:0] got_cmd;
		logic [31:0] got_host;
		time         t_cmd;
		time         t_host;
		load_exp  = shadow[5];
		host_data = next_rand();
		fork
			run_cmd(enc_load(rv_mem_pkg::FUNCT3_LW, 12'd0), 32'd20, 32'd0, got_cmd, t_cmd);
			begin
				repeat (2) @(negedge CLK);
				host_access(4'b1111, 32'd160, host_data, got_host, t_host);
			end
		join
		shadow[40] = host_data;
		check_value("LW under contention", got_cmd, load_exp);
		assert (t_host > t_cmd)
		else
		begin
			fail_stop("host access finished before the LSU command it should wait for");
		end
		host_access(4'b0000, 32'd160, 32'd0, got_host, t_host);
		check_value("host word 40 after contention", got_host, shadow[40]);
	endtask

	initial
	begin : main
		row_t        r;
		logic [31:0] got;
		time         t;
		int          n;
		cmd_req    = 1'b0;
		cmd_instr  = '0;
		cmd_rs1    = '0;
		cmd_rs2    = '0;
		host_req   = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		host_strb  = '0;
		rng        = 32'hdeb214a0;
		build_table();
		n = 0;
		while (NRST !== 1'b1)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				fail_stop("timeout: reset was never released");
		end
		// Table rows in order
		for (int k = 0; k < rows.size(); k++)
		begin
			r = rows[k];
			if (r.host)
				host_access(r.ctl[3:0], r.a, r.d, got, t);
			else
				run_cmd(r.ctl, r.a, r.d, got, t);
			if (r.chk)
				check_value($sformatf("row %0d", k), got, r.exp_data);
		end
		run_contention();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
hw/rv_mem_pkg.sv
hw/data_ram.sv
hw/mem_arbiter.sv
hw/lsu_addr_gen.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
verif/tb_clk_gen.sv
verif/tb_lsu_top.sv

// ==== Makefile ====
# Verilator simulation of the LSU subsystem

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lsu_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

# Build, run, then look for the pass line in the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
